//--- Makefile
# Verilator flow for the CSR file testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 0

SRCS    := $(wildcard *.sv *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+.
csr_pkg.sv
csr_access_check.sv
csr_machine_regs.sv
csr_counters.sv
csr_read_mux.sv
csr_top.sv
tb_clock_gen.sv
tb_csr_top.sv

//--- csr_access_check.sv
////////////////////////////////////////////////////////////////////////////
// CSR access check
// Privilege and read-only checks, set/clear merge and the write strobe
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "csr_config.svh"

module csr_access_check (
  input  logic [`CSR_ADDR_W-1:0] csr_addr,
  input  csr_pkg::csr_op_t       csr_op,
  input  logic [`CSR_XLEN-1:0]   csr_wdata,
  input  logic                   valid_write,
  input  csr_pkg::priv_level_t   curr_priv,
  input  logic [`CSR_XLEN-1:0]   old_val,
  output logic [`CSR_XLEN-1:0]   write_val,
  output logic                   write_en,
  output logic                   priv_invalid
);

  logic modify;     // Write, set or clear
  logic ro_region;  // Address bits 11:10 == 2'b11
  logic priv_low;   // Address privilege above current level

  assign modify = csr_op inside {csr_pkg::CSR_WRITE, csr_pkg::CSR_SET, csr_pkg::CSR_CLEAR};
  assign ro_region = &csr_addr[`CSR_ADDR_W-1 -: 2];
  assign priv_low = csr_addr[`CSR_ADDR_W-3 -: 2] > curr_priv;

  // Merge with the current value for set and clear
  always_comb begin
    case (csr_op)
      csr_pkg::CSR_SET:   write_val = old_val | csr_wdata;
      csr_pkg::CSR_CLEAR: write_val = old_val & ~csr_wdata;
      default:            write_val = csr_wdata;
    endcase
  end

  // Reads never fault here
  assign priv_invalid = modify & (ro_region | priv_low);

  assign write_en = valid_write & modify & ~priv_invalid;

endmodule

//--- csr_config.svh
////////////////////////////////////////////////////////////////////////////
// CSR file configuration
// Widths, hart id default and reset constants for the M/U CSR file
////////////////////////////////////////////////////////////////////////////

`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Register and address widths
`define CSR_XLEN    32
`define CSR_ADDR_W  12

// Full width of mcycle and minstret
`define CSR_CNT_W   64

// mhartid when the top level is not overridden
`define CSR_HART_ID_DEFAULT 0

// RV32 base with I (bit 8), M (bit 12) and U (bit 20)
`define CSR_MISA_VALUE 32'h4010_1100

// Only tw (bit 21) set out of reset
`define CSR_MSTATUS_RESET 32'h0020_0000

// User mode sees every counter out of reset
`define CSR_MCOUNTEREN_RESET 32'hFFFF_FFFF

`endif

//--- csr_counters.sv
////////////////////////////////////////////////////////////////////////////
// Cycle and retired-instruction counters
// 64-bit mcycle and minstret with inhibit control and half-word writes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "csr_config.svh"

module csr_counters (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic [`CSR_ADDR_W-1:0] csr_addr,
  input  logic                   write_en,
  input  logic [`CSR_XLEN-1:0]   write_val,
  input  logic                   inst_ret,
  input  logic                   cy_inhibit,
  input  logic                   ir_inhibit,
  output logic [`CSR_CNT_W-1:0]  cycle_count,
  output logic [`CSR_CNT_W-1:0]  instret_count
);

  localparam logic [`CSR_CNT_W-1:0] CNT_ONE = 1;

  logic [`CSR_CNT_W-1:0] cycle_next;
  logic [`CSR_CNT_W-1:0] instret_next;

  always_comb begin
    cycle_next   = cycle_count;
    instret_next = instret_count;

    if (!cy_inhibit) cycle_next = cycle_count + CNT_ONE;
    if (!ir_inhibit) instret_next = instret_count + {{(`CSR_CNT_W-1){1'b0}}, inst_ret};

    // A written half drops this cycle's increment
    if (write_en) begin
      case (csr_addr)
        csr_pkg::MCYCLE_ADDR:
          cycle_next = {cycle_count[`CSR_CNT_W-1:`CSR_XLEN], write_val};
        csr_pkg::MCYCLEH_ADDR:
          cycle_next = {write_val, cycle_count[`CSR_XLEN-1:0]};
        csr_pkg::MINSTRET_ADDR:
          instret_next = {instret_count[`CSR_CNT_W-1:`CSR_XLEN], write_val};
        csr_pkg::MINSTRETH_ADDR:
          instret_next = {write_val, instret_count[`CSR_XLEN-1:0]};
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycle_count   <= '0;
      instret_count <= '0;
    end else begin
      cycle_count   <= cycle_next;
      instret_count <= instret_next;
    end
  end

endmodule

//--- csr_machine_regs.sv
////////////////////////////////////////////////////////////////////////////
// Machine trap and counter-control registers
// Legalizes software writes and applies trap injection from the trap unit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "csr_config.svh"

module csr_machine_regs (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic [`CSR_ADDR_W-1:0] csr_addr,
  input  logic                   write_en,
  input  logic [`CSR_XLEN-1:0]   write_val,
  input  logic                   trap_inject,
  input  logic [`CSR_XLEN-1:0]   trap_mstatus,
  input  logic [`CSR_XLEN-1:0]   trap_mepc,
  input  logic [`CSR_XLEN-1:0]   trap_mcause,
  input  logic [`CSR_XLEN-1:0]   trap_mtval,
  output logic [`CSR_XLEN-1:0]   mstatus,
  output logic [`CSR_XLEN-1:0]   mtvec,
  output logic [`CSR_XLEN-1:0]   mie,
  output logic [`CSR_XLEN-1:0]   mip,
  output logic [`CSR_XLEN-1:0]   mscratch,
  output logic [`CSR_XLEN-1:0]   mepc,
  output logic [`CSR_XLEN-1:0]   mcause,
  output logic [`CSR_XLEN-1:0]   mtval,
  output logic [`CSR_XLEN-1:0]   mcounteren,
  output logic [`CSR_XLEN-1:0]   mcountinhibit
);

  // mie, mpie, mpp, mprv and tw
  localparam logic [`CSR_XLEN-1:0] MSTATUS_WMASK = 32'h0022_1888;
  // msie/msip, mtie/mtip, meie/meip
  localparam logic [`CSR_XLEN-1:0] IRQ_WMASK = 32'h0000_0888;
  // Bit 1 (time) is hardwired to zero
  localparam logic [`CSR_XLEN-1:0] CNT_WMASK = 32'hFFFF_FFFD;

  logic [`CSR_XLEN-1:0] mstatus_next;
  logic [`CSR_XLEN-1:0] mtvec_next;
  logic [`CSR_XLEN-1:0] mie_next;
  logic [`CSR_XLEN-1:0] mip_next;
  logic [`CSR_XLEN-1:0] mscratch_next;
  logic [`CSR_XLEN-1:0] mepc_next;
  logic [`CSR_XLEN-1:0] mcause_next;
  logic [`CSR_XLEN-1:0] mtval_next;
  logic [`CSR_XLEN-1:0] mcounteren_next;
  logic [`CSR_XLEN-1:0] mcountinhibit_next;

  // S and reserved mpp fall back to U
  function automatic logic [`CSR_XLEN-1:0] legal_mstatus(input logic [`CSR_XLEN-1:0] val);
    logic [`CSR_XLEN-1:0] res;
    res = val & MSTATUS_WMASK;
    if (val[12:11] == csr_pkg::S_MODE || val[12:11] == csr_pkg::RESERVED_MODE) begin
      res[12:11] = csr_pkg::U_MODE;
    end
    return res;
  endfunction

  always_comb begin
    mstatus_next       = mstatus;
    mtvec_next         = mtvec;
    mie_next           = mie;
    mip_next           = mip;
    mscratch_next      = mscratch;
    mepc_next          = mepc;
    mcause_next        = mcause;
    mtval_next         = mtval;
    mcounteren_next    = mcounteren;
    mcountinhibit_next = mcountinhibit;

    if (write_en) begin
      case (csr_addr)
        csr_pkg::MSTATUS_ADDR: mstatus_next = legal_mstatus(write_val);
        csr_pkg::MTVEC_ADDR: begin
          mtvec_next = write_val;
          if (write_val[1:0] > csr_pkg::VECTORED) begin
            mtvec_next[1:0] = csr_pkg::DIRECT;  // Reserved modes
          end
        end
        csr_pkg::MIE_ADDR:           mie_next = write_val & IRQ_WMASK;
        csr_pkg::MIP_ADDR:           mip_next = write_val & IRQ_WMASK;
        csr_pkg::MSCRATCH_ADDR:      mscratch_next = write_val;
        csr_pkg::MEPC_ADDR:          mepc_next = write_val;
        csr_pkg::MCAUSE_ADDR:        mcause_next = write_val;
        csr_pkg::MTVAL_ADDR:         mtval_next = write_val;
        csr_pkg::MCOUNTEREN_ADDR:    mcounteren_next = write_val & CNT_WMASK;
        csr_pkg::MCOUNTINHIBIT_ADDR: mcountinhibit_next = write_val & CNT_WMASK;
        default: ;  // Counters and read-only registers live elsewhere
      endcase
    end

    // Trap entry wins over a same-cycle software write
    if (trap_inject) begin
      mstatus_next = legal_mstatus(trap_mstatus);
      mepc_next    = trap_mepc;
      mcause_next  = trap_mcause;
      mtval_next   = trap_mtval;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= `CSR_MSTATUS_RESET;
      mtvec         <= '0;  // Base 0, DIRECT
      mie           <= '0;
      mip           <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= `CSR_MCOUNTEREN_RESET & CNT_WMASK;
      mcountinhibit <= '0;
    end else begin
      mstatus       <= mstatus_next;
      mtvec         <= mtvec_next;
      mie           <= mie_next;
      mip           <= mip_next;
      mscratch      <= mscratch_next;
      mepc          <= mepc_next;
      mcause        <= mcause_next;
      mtval         <= mtval_next;
      mcounteren    <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
    end
  end

endmodule

//--- csr_pkg.sv
////////////////////////////////////////////////////////////////////////////
// CSR package
// Privilege levels, CSR operations, CSR addresses and mtvec modes
////////////////////////////////////////////////////////////////////////////

`include "csr_config.svh"

package csr_pkg;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    S_MODE        = 2'd1,
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_t;

  // CSR_READ never modifies, the last three do
  typedef enum logic [2:0] {
    CSR_NONE  = 3'd0,
    CSR_READ  = 3'd1,
    CSR_WRITE = 3'd2,
    CSR_SET   = 3'd3,
    CSR_CLEAR = 3'd4
  } csr_op_t;

  typedef enum logic [`CSR_ADDR_W-1:0] {
    // Machine information, read-only region
    MVENDORID_ADDR     = 12'hF11,
    MARCHID_ADDR       = 12'hF12,
    MIMPID_ADDR        = 12'hF13,
    MHARTID_ADDR       = 12'hF14,
    MCONFIGPTR_ADDR    = 12'hF15,
    // Machine trap setup
    MSTATUS_ADDR       = 12'h300,
    MISA_ADDR          = 12'h301,
    MIE_ADDR           = 12'h304,
    MTVEC_ADDR         = 12'h305,
    MCOUNTEREN_ADDR    = 12'h306,
    MSTATUSH_ADDR      = 12'h310,
    MCOUNTINHIBIT_ADDR = 12'h320,
    // Machine trap handling
    MSCRATCH_ADDR      = 12'h340,
    MEPC_ADDR          = 12'h341,
    MCAUSE_ADDR        = 12'h342,
    MTVAL_ADDR         = 12'h343,
    MIP_ADDR           = 12'h344,
    // Machine counters
    MCYCLE_ADDR        = 12'hB00,
    MINSTRET_ADDR      = 12'hB02,
    MCYCLEH_ADDR       = 12'hB80,
    MINSTRETH_ADDR     = 12'hB82,
    // User counter views
    CYCLE_ADDR         = 12'hC00,
    INSTRET_ADDR       = 12'hC02,
    CYCLEH_ADDR        = 12'hC80,
    INSTRETH_ADDR      = 12'hC82
  } csr_addr_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } mtvec_mode_t;

endpackage

//--- csr_read_mux.sv
////////////////////////////////////////////////////////////////////////////
// CSR read return
// Selects the old value, gates user counters and flags bad accesses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "csr_config.svh"

module csr_read_mux #(
  parameter int HART_ID = `CSR_HART_ID_DEFAULT
) (
  input  logic [`CSR_ADDR_W-1:0] csr_addr,
  input  csr_pkg::csr_op_t       csr_op,
  input  csr_pkg::priv_level_t   curr_priv,
  input  logic                   priv_invalid,
  input  logic [`CSR_XLEN-1:0]   mstatus,
  input  logic [`CSR_XLEN-1:0]   mtvec,
  input  logic [`CSR_XLEN-1:0]   mie,
  input  logic [`CSR_XLEN-1:0]   mip,
  input  logic [`CSR_XLEN-1:0]   mscratch,
  input  logic [`CSR_XLEN-1:0]   mepc,
  input  logic [`CSR_XLEN-1:0]   mcause,
  input  logic [`CSR_XLEN-1:0]   mtval,
  input  logic [`CSR_XLEN-1:0]   mcounteren,
  input  logic [`CSR_XLEN-1:0]   mcountinhibit,
  input  logic [`CSR_CNT_W-1:0]  cycle_count,
  input  logic [`CSR_CNT_W-1:0]  instret_count,
  output logic [`CSR_XLEN-1:0]   old_val,
  output logic                   csr_invalid
);

  localparam logic [`CSR_XLEN-1:0] HART_ID_VAL = HART_ID;

  logic access;
  logic cy_blocked;    // User read of cycle with mcounteren.cy clear
  logic ir_blocked;    // Same for instret and mcounteren.ir
  logic addr_invalid;

  assign access = csr_op != csr_pkg::CSR_NONE;
  assign cy_blocked = access & (curr_priv == csr_pkg::U_MODE) & ~mcounteren[0];
  assign ir_blocked = access & (curr_priv == csr_pkg::U_MODE) & ~mcounteren[2];

  always_comb begin
    old_val      = '0;
    addr_invalid = 1'b0;
    case (csr_addr)
      csr_pkg::MVENDORID_ADDR,
      csr_pkg::MARCHID_ADDR,
      csr_pkg::MIMPID_ADDR,
      csr_pkg::MCONFIGPTR_ADDR,
      csr_pkg::MSTATUSH_ADDR:      old_val = '0;  // Hardwired zero
      csr_pkg::MHARTID_ADDR:       old_val = HART_ID_VAL;
      csr_pkg::MISA_ADDR:          old_val = `CSR_MISA_VALUE;
      csr_pkg::MSTATUS_ADDR:       old_val = mstatus;
      csr_pkg::MTVEC_ADDR:         old_val = mtvec;
      csr_pkg::MIE_ADDR:           old_val = mie;
      csr_pkg::MIP_ADDR:           old_val = mip;
      csr_pkg::MSCRATCH_ADDR:      old_val = mscratch;
      csr_pkg::MEPC_ADDR:          old_val = mepc;
      csr_pkg::MCAUSE_ADDR:        old_val = mcause;
      csr_pkg::MTVAL_ADDR:         old_val = mtval;
      csr_pkg::MCOUNTEREN_ADDR:    old_val = mcounteren;
      csr_pkg::MCOUNTINHIBIT_ADDR: old_val = mcountinhibit;
      csr_pkg::MCYCLE_ADDR:        old_val = cycle_count[`CSR_XLEN-1:0];
      csr_pkg::MCYCLEH_ADDR:       old_val = cycle_count[`CSR_CNT_W-1:`CSR_XLEN];
      csr_pkg::MINSTRET_ADDR:      old_val = instret_count[`CSR_XLEN-1:0];
      csr_pkg::MINSTRETH_ADDR:     old_val = instret_count[`CSR_CNT_W-1:`CSR_XLEN];
      // User views return zero when blocked
      csr_pkg::CYCLE_ADDR: begin
        addr_invalid = cy_blocked;
        if (!cy_blocked) old_val = cycle_count[`CSR_XLEN-1:0];
      end
      csr_pkg::CYCLEH_ADDR: begin
        addr_invalid = cy_blocked;
        if (!cy_blocked) old_val = cycle_count[`CSR_CNT_W-1:`CSR_XLEN];
      end
      csr_pkg::INSTRET_ADDR: begin
        addr_invalid = ir_blocked;
        if (!ir_blocked) old_val = instret_count[`CSR_XLEN-1:0];
      end
      csr_pkg::INSTRETH_ADDR: begin
        addr_invalid = ir_blocked;
        if (!ir_blocked) old_val = instret_count[`CSR_CNT_W-1:`CSR_XLEN];
      end
      default: addr_invalid = access;  // No such CSR
    endcase
  end

  assign csr_invalid = priv_invalid | addr_invalid;

endmodule

//--- csr_top.sv
////////////////////////////////////////////////////////////////////////////
// Machine-mode CSR file for an M/U RV32 hart
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "csr_config.svh"

module csr_top #(
  parameter int HART_ID = `CSR_HART_ID_DEFAULT
) (
  input  logic                   CLK,
  input  logic                   nRST,
  // CSR access from the core
  input  logic [`CSR_ADDR_W-1:0] csr_addr,
  input  csr_pkg::csr_op_t       csr_op,
  input  logic [`CSR_XLEN-1:0]   csr_wdata,
  input  logic                   valid_write,
  input  csr_pkg::priv_level_t   curr_priv,
  input  logic                   inst_ret,
  // Trap unit
  input  logic                   trap_inject,
  input  logic [`CSR_XLEN-1:0]   trap_mstatus,
  input  logic [`CSR_XLEN-1:0]   trap_mepc,
  input  logic [`CSR_XLEN-1:0]   trap_mcause,
  input  logic [`CSR_XLEN-1:0]   trap_mtval,
  output logic [`CSR_XLEN-1:0]   csr_rdata,
  output logic                   csr_invalid,
  output logic [`CSR_XLEN-1:0]   curr_mstatus,
  output logic [`CSR_XLEN-1:0]   curr_mtvec,
  output logic [`CSR_XLEN-1:0]   curr_mie,
  output logic [`CSR_XLEN-1:0]   curr_mip,
  output logic [`CSR_XLEN-1:0]   curr_mepc
);

  logic [`CSR_XLEN-1:0]  write_val;
  logic                  write_en;
  logic                  priv_invalid;
  logic [`CSR_XLEN-1:0]  mscratch;
  logic [`CSR_XLEN-1:0]  mcause;
  logic [`CSR_XLEN-1:0]  mtval;
  logic [`CSR_XLEN-1:0]  mcounteren;
  logic [`CSR_XLEN-1:0]  mcountinhibit;
  logic [`CSR_CNT_W-1:0] cycle_count;
  logic [`CSR_CNT_W-1:0] instret_count;

  csr_access_check access_check_inst (
    .csr_addr     (csr_addr),
    .csr_op       (csr_op),
    .csr_wdata    (csr_wdata),
    .valid_write  (valid_write),
    .curr_priv    (curr_priv),
    .old_val      (csr_rdata),  // Old value feeds the set/clear merge
    .write_val    (write_val),
    .write_en     (write_en),
    .priv_invalid (priv_invalid)
  );

  csr_machine_regs machine_regs_inst (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_addr      (csr_addr),
    .write_en      (write_en),
    .write_val     (write_val),
    .trap_inject   (trap_inject),
    .trap_mstatus  (trap_mstatus),
    .trap_mepc     (trap_mepc),
    .trap_mcause   (trap_mcause),
    .trap_mtval    (trap_mtval),
    .mstatus       (curr_mstatus),
    .mtvec         (curr_mtvec),
    .mie           (curr_mie),
    .mip           (curr_mip),
    .mscratch      (mscratch),
    .mepc          (curr_mepc),
    .mcause        (mcause),
    .mtval         (mtval),
    .mcounteren    (mcounteren),
    .mcountinhibit (mcountinhibit)
  );

  csr_counters counters_inst (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_addr      (csr_addr),
    .write_en      (write_en),
    .write_val     (write_val),
    .inst_ret      (inst_ret),
    .cy_inhibit    (mcountinhibit[0]),
    .ir_inhibit    (mcountinhibit[2]),
    .cycle_count   (cycle_count),
    .instret_count (instret_count)
  );

  csr_read_mux #(
    .HART_ID (HART_ID)
  ) read_mux_inst (
    .csr_addr      (csr_addr),
    .csr_op        (csr_op),
    .curr_priv     (curr_priv),
    .priv_invalid  (priv_invalid),
    .mstatus       (curr_mstatus),
    .mtvec         (curr_mtvec),
    .mie           (curr_mie),
    .mip           (curr_mip),
    .mscratch      (mscratch),
    .mepc          (curr_mepc),
    .mcause        (mcause),
    .mtval         (mtval),
    .mcounteren    (mcounteren),
    .mcountinhibit (mcountinhibit),
    .cycle_count   (cycle_count),
    .instret_count (instret_count),
    .old_val       (csr_rdata),
    .csr_invalid   (csr_invalid)
  );

endmodule

//--- csr_vectors.txt
# op priv addr wdata inst_ret trap_inject trap_mstatus trap_mepc trap_mcause trap_mtval
# exp_rdata exp_invalid mask, all hex; op 0 none 1 read 2 write 3 set 4 clear; priv 0 U 3 M
0 3 000 00000000 0 0 00000000 00000000 00000000 00000000 00000000 0 ffffffff
1 3 300 00000000 0 0 00000000 00000000 00000000 00000000 00200000 0 ffffffff
1 3 306 00000000 0 0 00000000 00000000 00000000 00000000 fffffffd 0 ffffffff
1 3 305 00000000 0 0 00000000 00000000 00000000 00000000 00000000 0 ffffffff
1 3 340 00000000 0 0 00000000 00000000 00000000 00000000 00000000 0 ffffffff
1 3 f14 00000000 0 0 00000000 00000000 00000000 00000000 00000005 0 ffffffff
1 3 301 00000000 0 0 00000000 00000000 00000000 00000000 40101100 0 ffffffff
1 3 304 00000000 0 0 00000000 00000000 00000000 00000000 00000000 0 ffffffff
# Write, set and clear on mscratch, then mtvec and mstatus legalization
2 3 340 12345678 0 0 00000000 00000000 00000000 00000000 00000000 0 ffffffff
3 3 340 0000ff00 0 0 00000000 00000000 00000000 00000000 12345678 0 ffffffff
4 3 340 12000008 0 0 00000000 00000000 00000000 00000000 1234ff78 0 ffffffff
1 3 340 00000000 0 0 00000000 00000000 00000000 00000000 0034ff70 0 ffffffff
2 3 305 00001003 0 0 00000000 00000000 00000000 00000000 00000000 0 ffffffff
1 3 305 00000000 0 0 00000000 00000000 00000000 00000000 00001000 0 ffffffff
2 3 300 ffffefff 0 0 00000000 00000000 00000000 00000000 00200000 0 ffffffff
1 3 300 00000000 0 0 00000000 00000000 00000000 00000000 00220088 0 ffffffff
# Access faults
2 3 f14 ffffffff 0 0 00000000 00000000 00000000 00000000 00000005 1 ffffffff
1 3 f14 00000000 0 0 00000000 00000000 00000000 00000000 00000005 0 ffffffff
2 0 340 00000000 0 0 00000000 00000000 00000000 00000000 0034ff70 1 ffffffff
3 0 340 ffffffff 0 0 00000000 00000000 00000000 00000000 0034ff70 1 ffffffff
4 0 340 ffffffff 0 0 00000000 00000000 00000000 00000000 0034ff70 1 ffffffff
1 3 340 00000000 0 0 00000000 00000000 00000000 00000000 0034ff70 0 ffffffff
1 3 7c0 00000000 0 0 00000000 00000000 00000000 00000000 00000000 1 ffffffff
# Counters inhibited, written and read back
2 3 320 00000005 0 0 00000000 00000000 00000000 00000000 00000000 0 ffffffff
2 3 b00 11111111 0 0 00000000 00000000 00000000 00000000 00000000 0 00000000
2 3 b80 22222222 0 0 00000000 00000000 00000000 00000000 00000000 0 00000000
2 3 b02 33333333 0 0 00000000 00000000 00000000 00000000 00000000 0 00000000
2 3 b82 44444444 0 0 00000000 00000000 00000000 00000000 00000000 0 00000000
1 3 b00 00000000 1 0 00000000 00000000 00000000 00000000 11111111 0 ffffffff
1 3 b80 00000000 0 0 00000000 00000000 00000000 00000000 22222222 0 ffffffff
1 3 b02 00000000 0 0 00000000 00000000 00000000 00000000 33333333 0 ffffffff
1 3 b82 00000000 0 0 00000000 00000000 00000000 00000000 44444444 0 ffffffff
# mcycle runs from the edge that ends the inhibit write
2 3 320 00000004 0 0 00000000 00000000 00000000 00000000 00000005 0 ffffffff
1 3 b00 00000000 0 0 00000000 00000000 00000000 00000000 11111111 0 ffffffff
1 3 b00 00000000 0 0 00000000 00000000 00000000 00000000 11111112 0 ffffffff
1 3 b80 00000000 0 0 00000000 00000000 00000000 00000000 22222222 0 ffffffff
1 3 b00 00000000 0 0 00000000 00000000 00000000 00000000 11111114 0 ffffffff
# minstret uninhibited, adds inst_ret
2 3 320 00000000 1 0 00000000 00000000 00000000 00000000 00000004 0 ffffffff
1 3 b02 00000000 1 0 00000000 00000000 00000000 00000000 33333333 0 ffffffff
1 3 b02 00000000 0 0 00000000 00000000 00000000 00000000 33333334 0 ffffffff
1 3 b02 00000000 1 0 00000000 00000000 00000000 00000000 33333334 0 ffffffff
1 3 b02 00000000 1 0 00000000 00000000 00000000 00000000 33333335 0 ffffffff
1 3 b02 00000000 0 0 00000000 00000000 00000000 00000000 33333336 0 ffffffff
1 3 b82 00000000 0 0 00000000 00000000 00000000 00000000 44444444 0 ffffffff
# User counter gating through mcounteren
2 3 306 00000000 0 0 00000000 00000000 00000000 00000000 fffffffd 0 ffffffff
1 0 c00 00000000 0 0 00000000 00000000 00000000 00000000 00000000 1 ffffffff
2 3 306 00000001 0 0 00000000 00000000 00000000 00000000 00000000 0 ffffffff
1 0 c00 00000000 0 0 00000000 00000000 00000000 00000000 1111111f 0 ffffffff
1 3 b00 00000000 0 0 00000000 00000000 00000000 00000000 11111120 0 ffffffff
1 0 c02 00000000 0 0 00000000 00000000 00000000 00000000 00000000 1 ffffffff
# Trap injection overrides a same-cycle mepc write
2 3 341 aaaaaaaa 0 1 00001880 80000100 0000000b deadbeef 00000000 0 ffffffff
1 3 341 00000000 0 0 00000000 00000000 00000000 00000000 80000100 0 ffffffff
1 3 342 00000000 0 0 00000000 00000000 00000000 00000000 0000000b 0 ffffffff
1 3 343 00000000 0 0 00000000 00000000 00000000 00000000 deadbeef 0 ffffffff
1 3 300 00000000 0 0 00000000 00000000 00000000 00000000 00001880 0 ffffffff
0 3 000 00000000 0 0 00000000 00000000 00000000 00000000 00000000 0 ffffffff

//--- tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset generator
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Release a quarter period after the last reset edge, clear of both edges
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #(PERIOD / 4);
    nRST = 1'b1;
  end

endmodule

//--- tb_csr_top.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the M/U CSR file
// Replays csr_vectors.txt and checks read data, the invalid flag and state
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "csr_config.svh"

module tb_csr_top;

  localparam int    CLK_PERIOD = 40;
  localparam int    HART_ID    = 5;
  localparam string VEC_FILE   = "csr_vectors.txt";

  typedef struct packed {
    logic [2:0]             op;
    logic [1:0]             priv;
    logic [`CSR_ADDR_W-1:0] addr;
    logic [`CSR_XLEN-1:0]   wdata;
    logic                   inst_ret;
    logic                   trap_inject;
    logic [`CSR_XLEN-1:0]   trap_mstatus;
    logic [`CSR_XLEN-1:0]   trap_mepc;
    logic [`CSR_XLEN-1:0]   trap_mcause;
    logic [`CSR_XLEN-1:0]   trap_mtval;
    logic [`CSR_XLEN-1:0]   rdata;
    logic                   invalid;
    logic [`CSR_XLEN-1:0]   mask;   // Zero bits are don't care
  } vector_t;

  logic                   CLK;
  logic                   nRST;
  logic [`CSR_ADDR_W-1:0] csr_addr;
  csr_pkg::csr_op_t       csr_op;
  logic [`CSR_XLEN-1:0]   csr_wdata;
  logic                   valid_write;
  csr_pkg::priv_level_t   curr_priv;
  logic                   inst_ret;
  logic                   trap_inject;
  logic [`CSR_XLEN-1:0]   trap_mstatus;
  logic [`CSR_XLEN-1:0]   trap_mepc;
  logic [`CSR_XLEN-1:0]   trap_mcause;
  logic [`CSR_XLEN-1:0]   trap_mtval;
  logic [`CSR_XLEN-1:0]   csr_rdata;
  logic                   csr_invalid;
  logic [`CSR_XLEN-1:0]   curr_mstatus;
  logic [`CSR_XLEN-1:0]   curr_mtvec;
  logic [`CSR_XLEN-1:0]   curr_mie;
  logic [`CSR_XLEN-1:0]   curr_mip;
  logic [`CSR_XLEN-1:0]   curr_mepc;

  vector_t vectors[$];
  int      vec_count = 0;
  bit      vectors_loaded = 1'b0;
  int      fail_count = 0;

  tb_clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (2)
  ) clock_gen_inst (
    .CLK  (CLK),
    .nRST (nRST)
  );

  csr_top #(
    .HART_ID (HART_ID)
  ) csr_top_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .csr_addr     (csr_addr),
    .csr_op       (csr_op),
    .csr_wdata    (csr_wdata),
    .valid_write  (valid_write),
    .curr_priv    (curr_priv),
    .inst_ret     (inst_ret),
    .trap_inject  (trap_inject),
    .trap_mstatus (trap_mstatus),
    .trap_mepc    (trap_mepc),
    .trap_mcause  (trap_mcause),
    .trap_mtval   (trap_mtval),
    .csr_rdata    (csr_rdata),
    .csr_invalid  (csr_invalid),
    .curr_mstatus (curr_mstatus),
    .curr_mtvec   (curr_mtvec),
    .curr_mie     (curr_mie),
    .curr_mip     (curr_mip),
    .curr_mepc    (curr_mepc)
  );

  // Lines starting with # are comments, 13 hex columns otherwise
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    vector_t     v;
    logic [31:0] f_op, f_priv, f_addr, f_wdata, f_ir, f_ti, f_tms;
    logic [31:0] f_tepc, f_tcause, f_tval, f_rdata, f_inv, f_mask;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", VEC_FILE);
      $display("SOME TESTS FAILED");
      $fatal(1, "vector file missing");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f_op, f_priv, f_addr, f_wdata, f_ir, f_ti, f_tms,
                    f_tepc, f_tcause, f_tval, f_rdata, f_inv, f_mask);
        if (n == 13) begin
          v.op           = f_op[2:0];
          v.priv         = f_priv[1:0];
          v.addr         = f_addr[`CSR_ADDR_W-1:0];
          v.wdata        = f_wdata;
          v.inst_ret     = f_ir[0];
          v.trap_inject  = f_ti[0];
          v.trap_mstatus = f_tms;
          v.trap_mepc    = f_tepc;
          v.trap_mcause  = f_tcause;
          v.trap_mtval   = f_tval;
          v.rdata        = f_rdata;
          v.invalid      = f_inv[0];
          v.mask         = f_mask;
          vectors.push_back(v);
        end else if (n > 0) begin
          $display("Malformed line in %s: %s", VEC_FILE, line);
          $display("SOME TESTS FAILED");
          $fatal(1, "bad vector line");
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_vector(input vector_t v);
    csr_op       = csr_pkg::csr_op_t'(v.op);
    curr_priv    = csr_pkg::priv_level_t'(v.priv);
    csr_addr     = v.addr;
    csr_wdata    = v.wdata;
    valid_write  = v.op != csr_pkg::CSR_NONE;
    inst_ret     = v.inst_ret;
    trap_inject  = v.trap_inject;
    trap_mstatus = v.trap_mstatus;
    trap_mepc    = v.trap_mepc;
    trap_mcause  = v.trap_mcause;
    trap_mtval   = v.trap_mtval;
  endtask

  // A state output holds the old value of the register being accessed
  task automatic compare_state(input string name, input int idx,
                               input logic [`CSR_XLEN-1:0] actual, input vector_t v);
    assert ((actual & v.mask) == (v.rdata & v.mask)) else begin
      fail_count++;
      $display("[FAIL] t=%0t vector %0d: %s %h, expected %h (mask %h)",
               $time, idx, name, actual, v.rdata, v.mask);
      $display("SOME TESTS FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_outputs(input int idx, input vector_t v);
    assert ((csr_rdata & v.mask) == (v.rdata & v.mask)) else begin
      fail_count++;
      $display("[FAIL] t=%0t vector %0d addr %h: csr_rdata %h, expected %h (mask %h)",
               $time, idx, v.addr, csr_rdata, v.rdata, v.mask);
      $display("SOME TESTS FAILED");
      $fatal(1, "csr_rdata mismatch");
    end
    assert (csr_invalid == v.invalid) else begin
      fail_count++;
      $display("[FAIL] t=%0t vector %0d addr %h: csr_invalid %b, expected %b",
               $time, idx, v.addr, csr_invalid, v.invalid);
      $display("SOME TESTS FAILED");
      $fatal(1, "csr_invalid mismatch");
    end
    if (v.op != csr_pkg::CSR_NONE) begin
      case (v.addr)
        csr_pkg::MSTATUS_ADDR: compare_state("curr_mstatus", idx, curr_mstatus, v);
        csr_pkg::MTVEC_ADDR:   compare_state("curr_mtvec", idx, curr_mtvec, v);
        csr_pkg::MIE_ADDR:     compare_state("curr_mie", idx, curr_mie, v);
        csr_pkg::MIP_ADDR:     compare_state("curr_mip", idx, curr_mip, v);
        csr_pkg::MEPC_ADDR:    compare_state("curr_mepc", idx, curr_mepc, v);
        default: ;
      endcase
    end
  endtask

  initial begin
    csr_addr     = '0;
    csr_op       = csr_pkg::CSR_NONE;
    csr_wdata    = '0;
    valid_write  = 1'b0;
    curr_priv    = csr_pkg::M_MODE;
    inst_ret     = 1'b0;
    trap_inject  = 1'b0;
    trap_mstatus = '0;
    trap_mepc    = '0;
    trap_mcause  = '0;
    trap_mtval   = '0;

    load_vectors();
    vec_count = vectors.size();
    vectors_loaded = 1'b1;

    @(posedge nRST);
    foreach (vectors[i]) begin
      @(negedge CLK);
      apply_vector(vectors[i]);
      #(CLK_PERIOD / 2 - 1);  // Just before the next rising edge
      check_outputs(i + 1, vectors[i]);
    end

    @(negedge CLK);
    csr_op      = csr_pkg::CSR_NONE;
    valid_write = 1'b0;
    trap_inject = 1'b0;

    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("SOME TESTS FAILED");
      $fatal(1, "%0d checks failed", fail_count);
    end
  end

  // Reset plus one clock per vector, with margin
  initial begin : watchdog
    wait (vectors_loaded);
    #((vec_count + 10) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", vec_count + 10);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule
